// File: src/icache_params.svh
// Geometry of the two-way instruction cache, fixed at one configuration
// Derived sizes follow from the base values and must not be set by hand

`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Physical address
`define ICACHE_AW               32

// Line, set and way geometry (log2)
`define ICACHE_P_LINE           5
`define ICACHE_P_SETS           6
`define ICACHE_P_WAYS           1

// Fetch window
`define ICACHE_FETCH_DW         64
`define ICACHE_P_FETCH_BYTES    3

// AXI read data bus
`define ICACHE_BUS_DW           32
`define ICACHE_P_BUS_BYTES      2

`define ICACHE_TAG_W            (`ICACHE_AW - `ICACHE_P_SETS - `ICACHE_P_LINE)
`define ICACHE_PAYLOAD_AW       (`ICACHE_P_SETS + `ICACHE_P_LINE - `ICACHE_P_FETCH_BYTES)
`define ICACHE_BEATS            (1 << (`ICACHE_P_LINE - `ICACHE_P_BUS_BYTES))

`endif

// File: src/icache_pkg.sv
// Shared types of the instruction cache
// Widths come from the geometry macros

`include "icache_params.svh"

package icache_pkg;

   // Controller states
   typedef enum logic [2:0] {
      S_BOOT       = 3'd0,
      S_IDLE       = 3'd1,
      S_REPLACE    = 3'd2,
      S_REFILL     = 3'd3,
      S_INVALIDATE = 3'd4,
      S_RELOAD_S1  = 3'd5
   } icache_state_e;

   typedef logic [`ICACHE_AW-1:0]                 paddr_t;
   typedef logic [`ICACHE_P_SETS-1:0]             set_idx_t;
   typedef logic [`ICACHE_TAG_W-1:0]              tag_t;
   typedef logic [`ICACHE_FETCH_DW-1:0]           fetch_win_t;
   typedef logic [`ICACHE_PAYLOAD_AW-1:0]         payload_addr_t;
   typedef logic [(1<<`ICACHE_P_FETCH_BYTES)-1:0] byte_en_t;
   typedef logic [`ICACHE_P_WAYS-1:0]             way_idx_t;

endpackage

// File: src/icache_way.sv
// One cache way with tag/valid RAM and payload RAM, both read registered
// Read data holds while the read enable is low

`timescale 1ns/1ps
`include "icache_params.svh"

module icache_way
(
   input  logic                      clk,
   // Tag/valid RAM
   input  icache_pkg::set_idx_t      i_set,
   input  logic                      i_tag_re,
   input  logic                      i_tag_we,
   input  icache_pkg::tag_t          i_tag_din,
   input  logic                      i_valid_din,
   // Payload RAM
   input  icache_pkg::payload_addr_t i_pay_addr,
   input  logic                      i_pay_re,
   input  icache_pkg::byte_en_t      i_pay_we,
   input  icache_pkg::fetch_win_t    i_pay_din,
   // Compare
   input  icache_pkg::tag_t          i_cmp_tag,
   output logic                      o_hit,
   output icache_pkg::fetch_win_t    o_payload
);

   localparam int TAG_V_W     = `ICACHE_TAG_W + 1;      // Tag plus valid bit
   localparam int SETS        = 1 << `ICACHE_P_SETS;
   localparam int PAY_DEPTH   = 1 << `ICACHE_PAYLOAD_AW;
   localparam int FETCH_BYTES = 1 << `ICACHE_P_FETCH_BYTES;

   logic [TAG_V_W-1:0]     tag_ram [SETS];
   icache_pkg::fetch_win_t pay_ram [PAY_DEPTH];
   logic [TAG_V_W-1:0]     tag_q;
   icache_pkg::tag_t       stored_tag;
   logic                   stored_valid;

   always_ff @(posedge clk)
   begin
      if (i_tag_we)
         tag_ram[i_set] <= {i_tag_din, i_valid_din};
      if (i_tag_re)
         tag_q <= tag_ram[i_set];                        // Old data on collision
   end

   // Byte-lane writes, so one bus beat fills part of a window
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < FETCH_BYTES; b++)
         if (i_pay_we[b])
            pay_ram[i_pay_addr][b*8 +: 8] <= i_pay_din[b*8 +: 8];
      if (i_pay_re)
         o_payload <= pay_ram[i_pay_addr];
   end

   assign {stored_tag, stored_valid} = tag_q;

   // Hit only on a valid entry
   assign o_hit = stored_valid & (stored_tag == i_cmp_tag);

endmodule

// File: src/icache_ctrl.sv
// Instruction cache controller: boot clear, miss refill, invalidate and stage-1 reload
// Refill assumes 8-beat INCR bursts starting at the line base, all OKAY
// Victim choice is round-robin, advancing once per replacement

`timescale 1ns/1ps
`include "icache_params.svh"

module icache_ctrl
(
   input  logic                               clk,
   input  logic                               i_arst_n,
   // Pipeline stages
   input  logic                               i_s1_valid,
   input  icache_pkg::paddr_t                 i_s1_addr,
   input  logic                               i_s2_valid,
   input  icache_pkg::paddr_t                 i_s2_addr,
   // Fetch side requests
   input  logic                               i_req,
   input  icache_pkg::paddr_t                 i_addr,
   input  logic                               i_inv,
   input  icache_pkg::paddr_t                 i_inv_addr,
   // Lookup result
   input  logic                               i_hit,
   input  icache_pkg::fetch_win_t             i_hit_payload,
   // Refill data
   input  logic                               i_r_beat,
   input  logic                               i_r_last,
   input  logic [`ICACHE_BUS_DW-1:0]          i_rdata,
   // RAM control
   output icache_pkg::set_idx_t               o_set,
   output logic                               o_ram_re,
   output logic [(1<<`ICACHE_P_WAYS)-1:0]     o_tag_we,
   output icache_pkg::tag_t                   o_tag_din,
   output logic                               o_valid_din,
   output icache_pkg::payload_addr_t          o_pay_addr,
   output icache_pkg::byte_en_t               o_pay_we,
   output icache_pkg::fetch_win_t             o_pay_din,
   // Bus read control
   output logic                               o_ar_start,
   output icache_pkg::paddr_t                 o_ar_addr,
   output logic                               o_refill,
   // Fetch side results
   output logic                               o_stall,
   output logic                               o_valid,
   output icache_pkg::fetch_win_t             o_ins
);

   localparam int WIN_W       = `ICACHE_P_LINE - `ICACHE_P_FETCH_BYTES;  // Window index in line
   localparam int LANE_W      = `ICACHE_P_FETCH_BYTES - `ICACHE_P_BUS_BYTES;
   localparam int LANES       = `ICACHE_FETCH_DW / `ICACHE_BUS_DW;
   localparam int LANE_BYTES  = `ICACHE_BUS_DW / 8;
   localparam int FETCH_BYTES = 1 << `ICACHE_P_FETCH_BYTES;
   localparam logic [`ICACHE_P_LINE-1:0] BEAT_BYTES = (1 << `ICACHE_P_LINE) / `ICACHE_BEATS;

   icache_pkg::icache_state_e state_q;
   icache_pkg::icache_state_e state_nxt;
   icache_pkg::set_idx_t      boot_cnt_q;
   logic [`ICACHE_P_LINE-1:0] refill_cnt_q;                   // Byte offset of next beat
   icache_pkg::way_idx_t      victim_q;
   icache_pkg::set_idx_t      inv_set_q;
   logic [LANE_W-1:0]         lane;
   logic                      win_match;
   icache_pkg::fetch_win_t    ins_nxt;

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         icache_pkg::S_BOOT:
            if (boot_cnt_q == '1)
               state_nxt = icache_pkg::S_IDLE;
         icache_pkg::S_IDLE:
            if (i_inv)
               state_nxt = icache_pkg::S_INVALIDATE;
            else if (i_s1_valid && !i_hit)
               state_nxt = icache_pkg::S_REPLACE;       // Miss in the compare stage
         icache_pkg::S_REPLACE:
            state_nxt = icache_pkg::S_REFILL;
         icache_pkg::S_REFILL:
            if (i_r_last)
               state_nxt = icache_pkg::S_RELOAD_S1;
         icache_pkg::S_INVALIDATE:
            state_nxt = icache_pkg::S_IDLE;
         icache_pkg::S_RELOAD_S1:
            state_nxt = icache_pkg::S_IDLE;
         default:
            state_nxt = icache_pkg::S_BOOT;
      endcase
   end

   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         state_q      <= icache_pkg::S_BOOT;
         boot_cnt_q   <= '0;
         refill_cnt_q <= '0;
         victim_q     <= '0;
      end
      else
      begin
         state_q <= state_nxt;
         if (state_q == icache_pkg::S_BOOT)
            boot_cnt_q <= boot_cnt_q + 1'b1;
         if (state_q == icache_pkg::S_REPLACE)
         begin
            refill_cnt_q <= '0;
            victim_q     <= victim_q + 1'b1;                // Round-robin
         end
         else if (state_q == icache_pkg::S_REFILL && i_r_beat)
            refill_cnt_q <= refill_cnt_q + BEAT_BYTES;
      end
   end

   // Set to invalidate, taken with the strobe
   always_ff @(posedge clk)
      if (state_q == icache_pkg::S_IDLE && i_inv)
         inv_set_q <= i_inv_addr[`ICACHE_P_LINE +: `ICACHE_P_SETS];

   // Tag RAM address by state
   always_comb
   begin
      case (state_q)
         icache_pkg::S_BOOT:       o_set = boot_cnt_q;
         icache_pkg::S_INVALIDATE: o_set = inv_set_q;
         icache_pkg::S_REPLACE:    o_set = i_s2_addr[`ICACHE_P_LINE +: `ICACHE_P_SETS];
         icache_pkg::S_RELOAD_S1:  o_set = i_s1_addr[`ICACHE_P_LINE +: `ICACHE_P_SETS];
         default:                  o_set = i_addr[`ICACHE_P_LINE +: `ICACHE_P_SETS];
      endcase
   end

   // Payload RAM address by state
   always_comb
   begin
      case (state_q)
         icache_pkg::S_REFILL:
            o_pay_addr = {i_s2_addr[`ICACHE_P_LINE +: `ICACHE_P_SETS],
                          refill_cnt_q[`ICACHE_P_FETCH_BYTES +: WIN_W]};
         icache_pkg::S_RELOAD_S1:
            o_pay_addr = i_s1_addr[`ICACHE_P_FETCH_BYTES +: `ICACHE_PAYLOAD_AW];
         default:
            o_pay_addr = i_addr[`ICACHE_P_FETCH_BYTES +: `ICACHE_PAYLOAD_AW];
      endcase
   end

   assign o_ram_re = (state_q == icache_pkg::S_IDLE && i_req) ||
                     (state_q == icache_pkg::S_RELOAD_S1);

   // Boot and invalidate clear both ways, replace writes the victim only
   always_comb
   begin
      o_tag_we = '0;
      if (state_q == icache_pkg::S_BOOT || state_q == icache_pkg::S_INVALIDATE)
         o_tag_we = '1;
      else if (state_q == icache_pkg::S_REPLACE)
         o_tag_we[victim_q] = 1'b1;
   end

   assign o_tag_din   = i_s2_addr[`ICACHE_AW-1 -: `ICACHE_TAG_W];
   assign o_valid_din = (state_q == icache_pkg::S_REPLACE);

   // Beat placement into its byte lanes of the window
   assign lane = refill_cnt_q[`ICACHE_P_BUS_BYTES +: LANE_W];

   always_comb
   begin
      o_pay_we = '0;
      if (state_q == icache_pkg::S_REFILL && i_r_beat)
         o_pay_we[lane*LANE_BYTES +: LANE_BYTES] = '1;
   end

   assign o_pay_din = {LANES{i_rdata}};

   // Beat belongs to the missed window
   assign win_match = (i_s2_addr[`ICACHE_P_FETCH_BYTES +: WIN_W] ==
                       refill_cnt_q[`ICACHE_P_FETCH_BYTES +: WIN_W]);

   always_comb
   begin
      ins_nxt = i_hit_payload;
      if (state_q == icache_pkg::S_REFILL)
      begin
         ins_nxt = o_ins;
         for (int b = 0; b < FETCH_BYTES; b++)
            if (win_match && o_pay_we[b])
               ins_nxt[b*8 +: 8] = o_pay_din[b*8 +: 8];   // Forward from bus
      end
   end

   always_ff @(posedge clk)
      if (state_q == icache_pkg::S_IDLE || state_q == icache_pkg::S_REFILL)
         o_ins <= ins_nxt;

   assign o_ar_start = (state_q == icache_pkg::S_REPLACE);
   assign o_ar_addr  = {i_s2_addr[`ICACHE_AW-1:`ICACHE_P_LINE], {`ICACHE_P_LINE{1'b0}}};
   assign o_refill   = (state_q == icache_pkg::S_REFILL);

   assign o_stall = (state_q != icache_pkg::S_IDLE);
   assign o_valid = i_s2_valid & ~o_stall;

endmodule

// File: src/icache_axi_rd.sv
// AXI read channel for line refills, AR and R only
// Sideband fields are left to the bus, which returns 8-beat INCR bursts

`timescale 1ns/1ps

module icache_axi_rd
(
   input  logic               clk,
   input  logic               i_arst_n,
   // From controller
   input  logic               i_ar_start,
   input  icache_pkg::paddr_t i_ar_addr,
   input  logic               i_refill,
   // AR channel
   input  logic               i_arready,
   output logic               o_arvalid,
   output icache_pkg::paddr_t o_araddr,
   // R channel
   output logic               o_rready,
   input  logic               i_rvalid,
   input  logic               i_rlast,
   // To controller
   output logic               o_r_beat,
   output logic               o_r_last
);

   logic ar_done;

   assign ar_done = o_arvalid & i_arready;

   // Valid held until the address handshake
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         o_arvalid <= 1'b0;
      else if (i_ar_start)
         o_arvalid <= 1'b1;
      else if (ar_done)
         o_arvalid <= 1'b0;
   end

   always_ff @(posedge clk)
      if (i_ar_start)
         o_araddr <= i_ar_addr;                             // Line base address

   // Ready only while the controller is refilling
   assign o_rready = i_refill;
   assign o_r_beat = i_rvalid & o_rready;
   assign o_r_last = o_r_beat & i_rlast;

endmodule

// File: src/icache_top.sv
// Two-way set-associative instruction cache with a two-stage lookup
// Requests are taken only while o_stall is low and results have no back-pressure
// Invalidate must not overlap a fetch in flight

`timescale 1ns/1ps
`include "icache_params.svh"

module icache_top
(
   input  logic                      clk,
   input  logic                      i_arst_n,
   // Fetch side
   input  logic                      i_req,
   input  icache_pkg::paddr_t        i_addr,
   input  logic                      i_inv,
   input  icache_pkg::paddr_t        i_inv_addr,
   output logic                      o_stall,
   output logic                      o_valid,
   output icache_pkg::fetch_win_t    o_ins,
   // AXI read bus
   output logic                      o_arvalid,
   output icache_pkg::paddr_t        o_araddr,
   input  logic                      i_arready,
   output logic                      o_rready,
   input  logic                      i_rvalid,
   input  logic [`ICACHE_BUS_DW-1:0] i_rdata,
   input  logic                      i_rlast
);

   localparam int WAYS        = 1 << `ICACHE_P_WAYS;
   localparam int FETCH_BYTES = 1 << `ICACHE_P_FETCH_BYTES;

   logic                      s1_valid_q;
   icache_pkg::paddr_t        s1_addr_q;
   logic                      s2_valid_q;
   icache_pkg::paddr_t        s2_addr_q;
   icache_pkg::set_idx_t      set;
   logic                      ram_re;
   logic [WAYS-1:0]           tag_we;
   icache_pkg::tag_t          tag_din;
   logic                      valid_din;
   icache_pkg::payload_addr_t pay_addr;
   icache_pkg::byte_en_t      pay_we;
   icache_pkg::fetch_win_t    pay_din;
   logic [WAYS-1:0]           fill_way_q;
   logic [WAYS-1:0]           way_hit;
   icache_pkg::fetch_win_t    way_payload [WAYS];
   logic                      hit;
   icache_pkg::fetch_win_t    hit_payload;
   logic                      ar_start;
   icache_pkg::paddr_t        ar_addr;
   logic                      refill;
   logic                      r_beat;
   logic                      r_last;

   // Pipeline advances only when not stalled
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         s1_valid_q <= 1'b0;
         s2_valid_q <= 1'b0;
      end
      else if (!o_stall)
      begin
         s1_valid_q <= i_req;
         s2_valid_q <= s1_valid_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!o_stall)
      begin
         s1_addr_q <= i_addr;
         s2_addr_q <= s1_addr_q;
      end
   end

   // Victim way of the running refill, taken from the replace tag write
   always_ff @(posedge clk or negedge i_arst_n)
   begin
      if (!i_arst_n)
         fill_way_q <= '0;
      else if (valid_din && (|tag_we))
         fill_way_q <= tag_we;
   end

   for (genvar w = 0; w < WAYS; w++)
   begin : g_way
      icache_way u_way
      (
         .clk         (clk),
         .i_set       (set),
         .i_tag_re    (ram_re),
         .i_tag_we    (tag_we[w]),
         .i_tag_din   (tag_din),
         .i_valid_din (valid_din),
         .i_pay_addr  (pay_addr),
         .i_pay_re    (ram_re),
         .i_pay_we    (pay_we & {FETCH_BYTES{fill_way_q[w]}}),
         .i_pay_din   (pay_din),
         .i_cmp_tag   (s1_addr_q[`ICACHE_AW-1 -: `ICACHE_TAG_W]),
         .o_hit       (way_hit[w]),
         .o_payload   (way_payload[w])
      );
   end

   // Payload of the hitting way
   always_comb
   begin
      hit_payload = '0;
      for (int w = 0; w < WAYS; w++)
         if (way_hit[w])
            hit_payload = way_payload[w];
   end

   assign hit = |way_hit;

   icache_ctrl u_ctrl
   (
      .clk           (clk),
      .i_arst_n      (i_arst_n),
      .i_s1_valid    (s1_valid_q),
      .i_s1_addr     (s1_addr_q),
      .i_s2_valid    (s2_valid_q),
      .i_s2_addr     (s2_addr_q),
      .i_req         (i_req),
      .i_addr        (i_addr),
      .i_inv         (i_inv),
      .i_inv_addr    (i_inv_addr),
      .i_hit         (hit),
      .i_hit_payload (hit_payload),
      .i_r_beat      (r_beat),
      .i_r_last      (r_last),
      .i_rdata       (i_rdata),
      .o_set         (set),
      .o_ram_re      (ram_re),
      .o_tag_we      (tag_we),
      .o_tag_din     (tag_din),
      .o_valid_din   (valid_din),
      .o_pay_addr    (pay_addr),
      .o_pay_we      (pay_we),
      .o_pay_din     (pay_din),
      .o_ar_start    (ar_start),
      .o_ar_addr     (ar_addr),
      .o_refill      (refill),
      .o_stall       (o_stall),
      .o_valid       (o_valid),
      .o_ins         (o_ins)
   );

   icache_axi_rd u_axi_rd
   (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ar_start (ar_start),
      .i_ar_addr  (ar_addr),
      .i_refill   (refill),
      .i_arready  (i_arready),
      .o_arvalid  (o_arvalid),
      .o_araddr   (o_araddr),
      .o_rready   (o_rready),
      .i_rvalid   (i_rvalid),
      .i_rlast    (i_rlast),
      .o_r_beat   (r_beat),
      .o_r_last   (r_last)
   );

endmodule

// File: tb/tb_clk_gen.sv
// Free-running testbench clock, 8 ns period
// Starts low at time zero

`timescale 1ns/1ps

module tb_clk_gen
(
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;                                   // Half period
   end

endmodule

// File: tb/axi_mem_model.sv
// AXI read responder with a computed memory, AR and R channels only
// Word at byte address A reads as A ^ 32'hC0DE0000, bursts are 8 beats of 4 bytes
// Outputs change 1 ns after the rising edge

`timescale 1ns/1ps

module axi_mem_model
(
   input  logic        clk,
   input  logic        i_arvalid,
   input  logic [31:0] i_araddr,
   output logic        o_arready,
   input  logic        i_rready,
   output logic        o_rvalid,
   output logic [31:0] o_rdata,
   output logic        o_rlast,
   output int          o_ar_count,
   output logic [31:0] o_last_araddr,
   output logic        o_stuck
);

   localparam int BEATS     = 8;
   localparam int R_TIMEOUT = 100;

   integer      seed;
   int          wait_cnt;
   logic [31:0] line_addr;

   function automatic logic [31:0] mem_word(input logic [31:0] a);
      return a ^ 32'hC0DE0000;
   endfunction

   function int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // Wait n cycles, ending 1 ns after the edge
   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic send_burst();
      for (int beat = 0; beat < BEATS; beat++)
      begin
         idle_cycles(rand_below(3));                      // Gap before the beat
         o_rvalid = 1'b1;
         o_rdata  = mem_word(line_addr + 32'(beat * 4));
         o_rlast  = (beat == BEATS - 1);
         wait_cnt = 0;
         while (i_rready !== 1'b1 && wait_cnt < R_TIMEOUT)
         begin
            idle_cycles(1);
            wait_cnt++;
         end
         if (wait_cnt == R_TIMEOUT)
         begin
            o_stuck  = 1'b1;
            o_rvalid = 1'b0;
            return;
         end
         idle_cycles(1);                                  // Beat taken at this edge
         o_rvalid = 1'b0;
         o_rlast  = 1'b0;
      end
   endtask

   initial
   begin
      seed          = 32'h7276;
      o_arready     = 1'b0;
      o_rvalid      = 1'b0;
      o_rdata       = '0;
      o_rlast       = 1'b0;
      o_ar_count    = 0;
      o_last_araddr = '0;
      o_stuck       = 1'b0;
      forever
      begin
         idle_cycles(1);
         if (i_arvalid === 1'b1)
         begin
            idle_cycles(rand_below(4));
            o_arready = 1'b1;
            line_addr = i_araddr;                         // Held until the handshake
            idle_cycles(1);
            o_arready     = 1'b0;
            o_ar_count    = o_ar_count + 1;
            o_last_araddr = line_addr;
            send_burst();
         end
      end
   end

endmodule

// File: tb/tb_icache.sv
// Directed tests of the two-way instruction cache with an AXI read model
// Inputs change 1 ns after the rising edge and outputs are sampled there too
// The run stops at the first error

`timescale 1ns/1ps
`include "icache_params.svh"

module tb_icache;

   localparam int TIMEOUT     = 200;
   localparam int BOOT_CYCLES = 1 << `ICACHE_P_SETS;

   logic                      clk;
   logic                      arst_n;
   logic                      req;
   icache_pkg::paddr_t        addr;
   logic                      inv;
   icache_pkg::paddr_t        inv_addr;
   logic                      stall;
   logic                      valid;
   icache_pkg::fetch_win_t    ins;
   logic                      arvalid;
   icache_pkg::paddr_t        araddr;
   logic                      arready;
   logic                      rready;
   logic                      rvalid;
   logic [`ICACHE_BUS_DW-1:0] rdata;
   logic                      rlast;
   int                        ar_count;
   logic [31:0]               last_araddr;
   logic                      mem_stuck;

   tb_clk_gen u_clk_gen
   (
      .clk (clk)
   );

   axi_mem_model u_mem
   (
      .clk           (clk),
      .i_arvalid     (arvalid),
      .i_araddr      (araddr),
      .o_arready     (arready),
      .i_rready      (rready),
      .o_rvalid      (rvalid),
      .o_rdata       (rdata),
      .o_rlast       (rlast),
      .o_ar_count    (ar_count),
      .o_last_araddr (last_araddr),
      .o_stuck       (mem_stuck)
   );

   icache_top u_dut
   (
      .clk        (clk),
      .i_arst_n   (arst_n),
      .i_req      (req),
      .i_addr     (addr),
      .i_inv      (inv),
      .i_inv_addr (inv_addr),
      .o_stall    (stall),
      .o_valid    (valid),
      .o_ins      (ins),
      .o_arvalid  (arvalid),
      .o_araddr   (araddr),
      .i_arready  (arready),
      .o_rready   (rready),
      .i_rvalid   (rvalid),
      .i_rdata    (rdata),
      .i_rlast    (rlast)
   );

   function automatic logic [31:0] mem_word(input logic [31:0] a);
      return a ^ 32'hC0DE0000;
   endfunction

   // Aligned window holding byte address a with the low word first
   function automatic logic [63:0] window_of(input logic [31:0] a);
      logic [31:0] base;
      base = {a[31:3], 3'b000};
      return {mem_word(base + 32'd4), mem_word(base)};
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic abort();
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("ERR %s got=0x%h exp=0x%h", name, got, exp);
         abort();
      end
   endtask

   // Model gives up when o_rready never comes
   always @(posedge mem_stuck)
   begin
      $display("AXI model gave up waiting for o_rready");
      abort();
   end

   // Wait until the cache takes requests again
   task automatic wait_idle(output int n);
      n = 0;
      while (stall && n < TIMEOUT)
      begin
         next_cycle();
         n++;
      end
      if (stall)
      begin
         $display("Timeout waiting for o_stall to fall");
         abort();
      end
   endtask

   // One fetch that returns the window and the cycles from request to o_valid
   task automatic fetch(input icache_pkg::paddr_t a, output logic [63:0] win, output int lat);
      int n;
      wait_idle(n);
      req  = 1'b1;
      addr = a;
      lat  = 0;
      do
      begin
         next_cycle();
         req = 1'b0;
         lat++;
      end
      while (!valid && lat < TIMEOUT);
      if (!valid)
      begin
         $display("Timeout waiting for o_valid on fetch of address %h", a);
         abort();
      end
      win = ins;
   endtask

   task automatic fetch_check(input icache_pkg::paddr_t a, input bit miss);
      logic [63:0] win;
      int          lat;
      int          ar_before;
      ar_before = ar_count;
      fetch(a, win, lat);
      check("o_ins", win, window_of(a));
      check("ar_count", ar_count - ar_before, miss);
      if (!miss)
         check("hit_latency", lat, 2);
   endtask

   task automatic test_boot();
      int n;
      check("o_stall", stall, 1);
      wait_idle(n);
      check("boot_cycles", n, BOOT_CYCLES);
      fetch_check(32'h0000_1234, 1'b1);
      check("o_araddr", last_araddr, 32'h0000_1220);     // Line base
   endtask

   // Another window of the line filled at boot
   task automatic test_hit();
      fetch_check(32'h0000_1238, 1'b0);
   endtask

   // Miss followed at once by a second line
   task automatic test_back_to_back();
      logic [63:0] exp_q[$];
      logic [63:0] exp;
      int          n;
      int          ar_before;
      wait_idle(n);
      ar_before = ar_count;
      exp_q     = {window_of(32'h0000_2040), window_of(32'h0000_3104)};
      req       = 1'b1;
      addr      = 32'h0000_2040;
      next_cycle();
      check("o_stall", stall, 0);
      addr = 32'h0000_3104;
      next_cycle();
      req = 1'b0;
      n   = 0;
      while (exp_q.size() > 0 && n < 2 * TIMEOUT)
      begin
         if (valid)
         begin
            exp = exp_q.pop_front();
            check("o_ins", ins, exp);
         end
         next_cycle();
         n++;
      end
      if (exp_q.size() > 0)
      begin
         $display("Timeout waiting for both back-to-back results");
         abort();
      end
      check("ar_count", ar_count - ar_before, 2);
   endtask

   // X, Y and Z share set 5
   task automatic test_replacement();
      fetch_check(32'h0001_00A0, 1'b1);
      fetch_check(32'h0002_00A8, 1'b1);
      fetch_check(32'h0001_00A0, 1'b0);
      fetch_check(32'h0002_00A8, 1'b0);
      fetch_check(32'h0003_00B0, 1'b1);                  // Evicts X
      fetch_check(32'h0002_00A8, 1'b0);
      fetch_check(32'h0001_00A0, 1'b1);
   endtask

   task automatic test_invalidate();
      int n;
      fetch_check(32'h0000_1230, 1'b0);
      next_cycle();
      wait_idle(n);
      inv      = 1'b1;
      inv_addr = 32'h0000_1234;
      next_cycle();
      inv = 1'b0;
      check("o_stall", stall, 1);
      fetch_check(32'h0000_1230, 1'b1);
   endtask

   initial
   begin
      arst_n   = 1'b0;
      req      = 1'b0;
      addr     = '0;
      inv      = 1'b0;
      inv_addr = '0;
      next_cycle();
      check("o_valid", valid, 0);
      check("o_arvalid", arvalid, 0);
      check("o_rready", rready, 0);
      repeat (3)
         next_cycle();
      arst_n = 1'b1;
      test_boot();
      test_hit();
      test_back_to_back();
      test_replacement();
      test_invalidate();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: filelist.f
+incdir+src
src/icache_pkg.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache_axi_rd.sv
src/icache_top.sv
tb/tb_clk_gen.sv
tb/axi_mem_model.sv
tb/tb_icache.sv

// File: Makefile
# Verilator build and run of the instruction cache testbench

TOP := tb_icache

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f filelist.f --Mdir obj_dir -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
